/* design/lsu_pkg.sv */
package lsu_pkg;

  typedef logic [31:0] xlen_t;   // data or address word
  typedef logic [3:0]  sel_t;    // wishbone byte select
  typedef logic [2:0]  funct3_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUS  = 2'd1,
    ST_RESP = 2'd2
  } lsu_state_e;

  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  typedef struct packed {
    lsu_op_e op;
    funct3_t funct3;
    xlen_t   addr;    // execute result
    xlen_t   wdata;   // rs2
  } lsu_req_t;

  typedef struct packed {
    xlen_t rdata;     // extended load value
    logic  err;
  } lsu_rsp_t;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    xlen_t adr;
    xlen_t dat;
    sel_t  sel;
  } wb_m2s_t;

  typedef struct packed {
    xlen_t dat;
    logic  ack;
  } wb_s2m_t;

endpackage

/* design/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
  input  funct3_t    funct3,
  input  logic [1:0] addr_lo,
  input  xlen_t      wdata,
  output xlen_t      dat,
  output sel_t       sel
);

  logic [1:0] size;

  assign size = funct3[1:0]; // unsigned flag ignored here

  always_comb begin
    case (size)
      2'b00: begin
        dat = {4{wdata[7:0]}};            // byte on every lane
        sel = sel_t'(4'b0001 << addr_lo);
      end
      2'b01: begin
        dat = {2{wdata[15:0]}};
        sel = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dat = wdata;
        sel = 4'b1111;
      end
    endcase
  end

  // lanes must agree with the byte position
  // the ram writes only bytes flagged in sel, so the
  // replicated copies outside the selected lanes are dropped there

endmodule

/* design/lsu_load_extract.sv */
`timescale 1ns/1ps

module lsu_load_extract import lsu_pkg::*; (
  input  funct3_t    funct3,
  input  logic [1:0] addr_lo,
  input  xlen_t      rdata,
  output xlen_t      value
);

  xlen_t      shifted;
  logic [4:0] shamt;

  assign shamt   = {addr_lo, 3'b000};  // byte offset in bits
  assign shifted = rdata >> shamt;

  always_comb begin
    case (funct3)
      F3_B: begin
        value = {{24{shifted[7]}}, shifted[7:0]};   // lb
      end
      F3_H: begin
        value = {{16{shifted[15]}}, shifted[15:0]}; // lh
      end
      F3_BU: begin
        value = {24'd0, shifted[7:0]};
      end
      F3_HU: begin
        value = {16'd0, shifted[15:0]};
      end
      default: begin
        value = rdata; // lw, word is aligned
      end
    endcase
  end

endmodule

/* design/lsu_data_ram.sv */
`timescale 1ns/1ps

module lsu_data_ram import lsu_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_m2s_t wb_in,
  output wb_s2m_t wb_out
);

  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  xlen_t          mem [RAM_WORDS];
  xlen_t          rd_q;
  logic           ack_q;
  logic           hit;
  logic [AW-1:0]  word_idx;

  assign hit      = wb_in.cyc & wb_in.stb & ~ack_q; // new cycle waiting for ack
  assign word_idx = wb_in.adr[AW+1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;   // one cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      rd_q <= mem[word_idx];
      if (wb_in.we) begin
        for (int b = 0; b < 4; b++) begin
          if (wb_in.sel[b]) begin
            mem[word_idx][8*b +: 8] <= wb_in.dat[8*b +: 8];
          end
        end
      end
    end
  end

  assign wb_out = '{dat: rd_q, ack: ack_q};

endmodule

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  lsu_req_t req,
  input  xlen_t    aligned_dat,
  input  sel_t     aligned_sel,
  input  xlen_t    load_value,
  input  wb_s2m_t  wb_in,
  output logic     req_ready,
  output lsu_req_t hold_req,
  output logic     rsp_valid,
  output lsu_rsp_t rsp,
  output wb_m2s_t  wb_out
);

  lsu_state_e state_q;
  logic       accept;
  logic       op_ok;
  logic       align_ok;
  logic       range_ok;
  logic       req_ok;
  logic       in_bus;
  logic       bus_done;

  assign req_ready = (state_q == ST_IDLE);
  assign accept    = req_valid & req_ready;
  assign in_bus    = (state_q == ST_BUS);
  assign bus_done  = in_bus & wb_in.ack;
  assign rsp_valid = (state_q == ST_RESP);

  always_comb begin
    case (req.op)
      LSU_LOAD:  op_ok = (req.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
      LSU_STORE: op_ok = (req.funct3 inside {F3_B, F3_H, F3_W});
      default:   op_ok = 1'b0; // none and the spare encoding
    endcase
  end

  always_comb begin
    case (req.funct3)
      F3_H, F3_HU: align_ok = ~req.addr[0];
      F3_W:        align_ok = (req.addr[1:0] == 2'b00);
      default:     align_ok = 1'b1;
    endcase
  end

  assign range_ok = ((req.addr >> 2) < xlen_t'(RAM_WORDS)); // word index inside ram
  assign req_ok   = op_ok & align_ok & range_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= req_ok ? ST_BUS : ST_RESP; // refused requests skip the bus
          end
        end
        ST_BUS: begin
          if (wb_in.ack) begin
            state_q <= ST_RESP;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_req <= req;
    end
    if (accept && !req_ok) begin
      rsp <= '{rdata: '0, err: 1'b1};
    end else if (bus_done) begin
      rsp.rdata <= (hold_req.op == LSU_LOAD) ? load_value : '0; // stores return zero
      rsp.err   <= 1'b0;
    end
  end

  // classic cycle, held stable until ack
  assign wb_out = '{
    cyc: in_bus,
    stb: in_bus,
    we:  in_bus & (hold_req.op == LSU_STORE),
    adr: {hold_req.addr[31:2], 2'b00},
    dat: aligned_dat,
    sel: aligned_sel
  };

endmodule

/* design/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  lsu_req_t req,
  output logic     req_ready,
  output logic     rsp_valid,
  output lsu_rsp_t rsp
);

  lsu_req_t hold_req;
  wb_m2s_t  wb_m2s;
  wb_s2m_t  wb_s2m;
  xlen_t    aligned_dat;
  sel_t     aligned_sel;
  xlen_t    load_value;

  lsu_ctrl #(
    .RAM_WORDS (RAM_WORDS)
  ) i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .aligned_dat (aligned_dat),
    .aligned_sel (aligned_sel),
    .load_value  (load_value),
    .wb_in       (wb_s2m),
    .req_ready   (req_ready),
    .hold_req    (hold_req),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .wb_out      (wb_m2s)
  );

  lsu_store_align i_store_align (
    .funct3  (hold_req.funct3),
    .addr_lo (hold_req.addr[1:0]),
    .wdata   (hold_req.wdata),
    .dat     (aligned_dat),
    .sel     (aligned_sel)
  );

  lsu_load_extract i_load_extract (
    .funct3  (hold_req.funct3),
    .addr_lo (hold_req.addr[1:0]),
    .rdata   (wb_s2m.dat),
    .value   (load_value)
  );

  lsu_data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) i_data_ram (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_in  (wb_m2s),
    .wb_out (wb_s2m)
  );

endmodule

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int RAM_WORDS  = 256;
  localparam int MAX_ROWS   = 64;
  localparam int RST_CYCLES = 8;

  typedef struct packed {
    lsu_req_t req;
    logic     hold;      // keep req_valid high into the next row
    logic     exp_err;
    xlen_t    exp_rdata;
  } row_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req_valid;
  lsu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  lsu_rsp_t rsp;

  row_t        rows [MAX_ROWS];
  int          n_rows;
  logic [7:0]  ref_mem [RAM_WORDS*4]; // byte model of the ram
  logic [15:0] lfsr_q = 16'd56;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  lsu_top #(
    .RAM_WORDS (RAM_WORDS)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic compare(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic xlen_t take_bits(input int n);
    xlen_t v;
    logic  fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic void add_row(input lsu_op_e op, input funct3_t f3, input xlen_t addr,
                                  input xlen_t wdata, input logic hold);
    row_t r;
    r           = '0;
    r.req.op    = op;
    r.req.funct3 = f3;
    r.req.addr  = addr;
    r.req.wdata = wdata;
    r.hold      = hold;
    rows[n_rows] = r;
    n_rows++;
  endfunction

  function automatic int access_bytes(input funct3_t f3);
    case (f3)
      F3_B, F3_BU: return 1;
      F3_H, F3_HU: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_legal(input lsu_req_t r);
    logic pair_ok;
    pair_ok = (r.op == LSU_LOAD && r.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) ||
              (r.op == LSU_STORE && r.funct3 inside {F3_B, F3_H, F3_W});
    return pair_ok && ((r.addr & xlen_t'(access_bytes(r.funct3) - 1)) == '0) &&
           ((r.addr >> 2) < xlen_t'(RAM_WORDS));
  endfunction

  function automatic void build_table();
    xlen_t a;
    n_rows = 0;
    for (int k = 0; k < 4; k++) begin
      a = (k == 3) ? 32'h3fc : (take_bits(8) << 2);  // last word of the ram
      add_row(LSU_STORE, F3_W, a, take_bits(32), 1'b1);
      add_row(LSU_LOAD, F3_W, a, '0, k != 3);
    end
    add_row(LSU_STORE, F3_W, 32'h40, take_bits(32), 1'b0);
    for (int off = 0; off < 4; off++) begin
      add_row(LSU_STORE, F3_B, 32'h40 + off, take_bits(32), 1'b0);
      add_row(LSU_LOAD, F3_W, 32'h40, '0, 1'b0);  // other lanes keep old bytes
    end
    for (int off = 0; off < 4; off += 2) begin
      add_row(LSU_STORE, F3_H, 32'h40 + off, take_bits(32), 1'b0);
      add_row(LSU_LOAD, F3_W, 32'h40, '0, 1'b0);
    end
    add_row(LSU_STORE, F3_B, 32'h40 + take_bits(2), take_bits(32), 1'b0);
    add_row(LSU_STORE, F3_H, 32'h40 + (take_bits(1) << 1), take_bits(32), 1'b0);
    add_row(LSU_LOAD, F3_W, 32'h40, '0, 1'b0);
    add_row(LSU_STORE, F3_W, 32'h80, 32'h89abcdef, 1'b0); // top bit set in every byte
    for (int off = 0; off < 4; off++) begin
      add_row(LSU_LOAD, F3_B, 32'h80 + off, '0, 1'b0);
      add_row(LSU_LOAD, F3_BU, 32'h80 + off, '0, 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_row(LSU_LOAD, F3_H, 32'h80 + off, '0, 1'b0);
      add_row(LSU_LOAD, F3_HU, 32'h80 + off, '0, 1'b0);
    end
    add_row(LSU_STORE, F3_H, 32'h41, take_bits(32), 1'b1);
    add_row(LSU_STORE, F3_W, 32'h42, take_bits(32), 1'b1);
    add_row(LSU_LOAD, F3_W, 32'h81, '0, 1'b1);
    add_row(LSU_LOAD, F3_H, 32'h83, '0, 1'b1);
    add_row(LSU_LOAD, 3'b011, 32'h40, '0, 1'b1);
    add_row(LSU_STORE, F3_BU, 32'h40, take_bits(32), 1'b1);
    add_row(LSU_NONE, F3_W, 32'h40, take_bits(32), 1'b1);
    add_row(LSU_LOAD, F3_W, 32'h400, '0, 1'b1);          // first word past the ram
    add_row(LSU_STORE, F3_W, 32'hfffc, take_bits(32), 1'b0);
    add_row(LSU_LOAD, F3_W, 32'h40, '0, 1'b0);
    add_row(LSU_LOAD, F3_W, 32'h80, '0, 1'b0);
  endfunction

  function automatic void fill_expected();
    lsu_req_t r;
    int       nb;
    int       ba;
    xlen_t    v;
    for (int i = 0; i < n_rows; i++) begin
      r  = rows[i].req;
      nb = access_bytes(r.funct3);
      v  = '0;
      if (!is_legal(r)) begin
        rows[i].exp_err = 1'b1;
      end else if (r.op == LSU_STORE) begin
        for (int b = 0; b < nb; b++) begin
          ba          = int'(r.addr) + b;
          ref_mem[ba] = r.wdata[8*b +: 8];  // low bytes of rs2
        end
      end else begin
        for (int b = 0; b < nb; b++) begin
          ba           = int'(r.addr) + b;
          v[8*b +: 8]  = ref_mem[ba];
        end
        if (r.funct3 == F3_B && v[7]) begin
          v[31:8] = '1;
        end
        if (r.funct3 == F3_H && v[15]) begin
          v[31:16] = '1;
        end
      end
      rows[i].exp_rdata = v;
    end
  endfunction

  task automatic apply_row(input int i);
    int   lat;
    int   exp_lat;
    logic held;
    exp_lat = rows[i].exp_err ? 1 : 3;
    held    = (i > 0) && rows[i-1].hold;
    if (!held) begin
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= rows[i].req;
      @(negedge clk);
    end
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk); // accept edge
    if (rows[i].hold) begin
      req <= rows[i+1].req;
    end else begin
      req_valid <= 1'b0;
    end
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      compare("req_ready", xlen_t'(req_ready), '0);
    end while (!rsp_valid);
    compare("rsp latency", xlen_t'(lat), xlen_t'(exp_lat));
    compare("rsp.err", xlen_t'(rsp.err), xlen_t'(rows[i].exp_err));
    compare("rsp.rdata", rsp.rdata, rows[i].exp_rdata);
    @(negedge clk);
    compare("rsp_valid", xlen_t'(rsp_valid), '0); // single cycle pulse
    compare("req_ready", xlen_t'(req_ready), 32'd1);
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    build_table();
    fill_expected();
    cycle_limit = n_rows * 4 + RST_CYCLES + 50;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare("req_ready", xlen_t'(req_ready), 32'd1);
    compare("rsp_valid", xlen_t'(rsp_valid), '0);
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* lsu_top.f */
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_extract.sv
design/lsu_data_ram.sv
design/lsu_ctrl.sv
design/lsu_top.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module lsu_tb -f lsu_top.f -o lsu_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

{ ./obj_dir/lsu_sim > sim.log 2>&1 || true; } && cat sim.log

grep -qx ">>> PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
